// File: include/quirk_table.svh
`ifndef QUIRK_TABLE_SVH
`define QUIRK_TABLE_SVH

// One entry per known header title
typedef struct packed {
	logic [95:0] title;                         // Twelve title bytes, zero padded at the end
	quirk_t      quirks;
} quirk_entry_t;

localparam int QUIRK_ENTRIES = 15;

// Flag bits from MSB are sram_off, memory_remap, gpio, tilt, solar
localparam quirk_entry_t QUIRK_TABLE [QUIRK_ENTRIES] = '{
	'{"ROCKY BOXING",             5'b10000},   // Save chip absent
	'{"DBZ LGCYGOKU",             5'b10000},
	'{{"IRIDIONII", 24'h0},       5'b10000},
	'{{"BOMBER MAN", 16'h0},      5'b11000},   // NES classic series
	'{{"CASTLEVANIA", 8'h0},      5'b11000},
	'{{"SUPER MARIO", 8'h0},      5'b11000},
	'{{"ZELDA 1", 40'h0},         5'b11000},
	'{"SUPER MARIO2",             5'b11000},
	'{"POKEMON EMER",             5'b00100},   // RTC on GPIO
	'{"POKEMON RUBY",             5'b00100},
	'{"POKEMON SAPP",             5'b00100},
	'{{"BOKTAI", 48'h0},          5'b00101},   // RTC plus light sensor
	'{"WARIOTWISTED",             5'b00100},   // Gyro
	'{{"YOSHI TOPSY", 8'h0},      5'b00010},
	'{"HAPPYPANECHU",             5'b00010}
};

`endif

// File: hdl/gba_loader_pkg.sv
`default_nettype none

package gba_loader_pkg;

	//==========================================================================
	// Geometry and constants
	//==========================================================================
	localparam int ADDR_W      = 27;                // Download byte address
	localparam int DATA_W      = 16;                // Download half-word
	localparam int BIOS_ADDR_W = 12;                // BIOS RAM word address

	localparam logic [7:0] IDX_BIOS  = 8'd0;        // Slot 0 carries the BIOS image
	localparam logic [7:0] IDX_CHEAT = 8'd255;      // Last slot carries cheat records

	localparam logic [ADDR_W-1:0] ROM_BASE_RESET = ADDR_W'('hC0000); // ROM offset in game memory

	localparam int ROM_CREDITS   = 2;               // Writes the memory side can take at once
	localparam int CHEAT_CREDITS = 1;               // Cheat engine takes one record at a time

	// Cartridge header layout
	localparam int TITLE_ADDR = 'hA0;
	localparam int TITLE_LEN  = 12;
	localparam logic [71:0] FLASH_MARKER = "FLASH1M_V"; // Marks 128K flash carts

	//==========================================================================
	// Bus bundles
	//==========================================================================
	typedef struct packed {
		logic              active;                  // Download in progress
		logic [7:0]        index;                   // Slot selected by the host
		logic [ADDR_W-1:0] addr;                    // Byte address of the half-word
		logic [DATA_W-1:0] data;                    // Low byte comes first in the file
		logic              wr;                      // One beat
	} ioctl_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;                    // Byte address in game memory
		logic [DATA_W-1:0] data;
	} rom_wr_t;

	typedef struct packed {
		logic                   wr;
		logic [BIOS_ADDR_W-1:0] addr;               // Word address
		logic [31:0]            data;
	} bios_wr_t;

	// Same field order as the cheat engine expects, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic sram_off;                             // Cart has no SRAM despite the save type
		logic memory_remap;                         // NES classics mirror their ROM
		logic gpio;                                 // RTC or sensor on the GPIO port
		logic tilt;
		logic solar;
	} quirk_t;

	typedef struct packed {
		logic              loaded;
		logic [1:0]        cart_type;
		logic              flash_1m;
		quirk_t            quirks;
		logic [ADDR_W-1:0] last_addr;
	} cart_info_t;

	typedef struct packed {
		logic              homebrew_bios;           // Keep the built-in BIOS
		logic              cheats_off;
		logic [ADDR_W-1:0] rom_base;
	} cfg_t;

	typedef struct packed {
		logic        wr;
		logic [1:0]  addr;
		logic [31:0] data;
	} reg_req_t;

endpackage

`default_nettype wire

// File: hdl/credit_sender.sv
`timescale 1ns/1ps
`default_nettype none

module credit_sender #(
	parameter type PAYLOAD = logic,
	parameter int  CREDITS = 1
) (
	input  logic   clk_sys,
	input  logic   reset,
	input  logic   push,
	input  PAYLOAD item,
	output logic   full,
	output logic   valid,
	output PAYLOAD data,
	input  logic   credit
);
	typedef logic [$clog2(CREDITS+1)-1:0] credit_t;

	PAYLOAD     buf_q [2];            // Two-entry queue
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;                // Items held
	credit_t    credit_cnt;           // Credits still free at the receiver
	logic       accept;
	logic       send;
	logic       valid_q;
	PAYLOAD     data_q;

	assign full   = (count == 2'd2);
	assign accept = push && !full;
	// One idle cycle after each pulse keeps every item a separate one-cycle valid
	assign send   = (count != 2'd0) && (credit_cnt != '0) && !valid_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr     <= 1'b0;
			rd_ptr     <= 1'b0;
			count      <= 2'd0;
			credit_cnt <= credit_t'(CREDITS);
			valid_q    <= 1'b0;
		end else begin
			valid_q <= send;
			count   <= count + 2'(accept) - 2'(send);
			if (accept) wr_ptr <= ~wr_ptr;
			if (send)   rd_ptr <= ~rd_ptr;   // Oldest item leaves first
			if (send && !credit) begin
				credit_cnt <= credit_cnt - 1'b1;
			end else if (!send && credit && (credit_cnt != credit_t'(CREDITS))) begin
				credit_cnt <= credit_cnt + 1'b1;   // Saturates at CREDITS
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) buf_q[wr_ptr] <= item;
		if (send)   data_q        <= buf_q[rd_ptr];
	end

	assign valid = valid_q;
	assign data  = data_q;

endmodule

`default_nettype wire

// File: hdl/download_decode.sv
`timescale 1ns/1ps
`default_nettype none

module download_decode (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  gba_loader_pkg::ioctl_t      ioctl,
	input  gba_loader_pkg::cfg_t        cfg,
	output logic                        rom_push,
	output gba_loader_pkg::rom_wr_t     rom_item,
	input  logic                        rom_full,
	output logic                        cheat_push,
	output gba_loader_pkg::cheat_code_t cheat_item,
	input  logic                        cheat_full,
	output logic                        ioctl_wait,
	output gba_loader_pkg::bios_wr_t    bios,
	output logic                        cheat_clear
);
	import gba_loader_pkg::*;

	logic                   is_bios;
	logic                   is_cheat;
	logic                   is_cart;
	logic                   active_q;       // Previous active, for start detection
	logic                   dl_start;
	logic                   bios_wr_q;
	logic [BIOS_ADDR_W-1:0] bios_addr_q;
	logic [31:0]            bios_data_q;
	logic                   cheat_clear_q;
	cheat_code_t            code_q;         // Record under assembly

	//==========================================================================
	// Classification
	//==========================================================================
	assign is_bios  = ioctl.active && (ioctl.index == IDX_BIOS);
	assign is_cheat = ioctl.active && (ioctl.index == IDX_CHEAT);
	assign is_cart  = ioctl.active && !is_bios && !is_cheat; // Everything else is a game
	assign dl_start = ioctl.active && !active_q;

	assign ioctl_wait = rom_full | cheat_full;  // Host stalls on either backlog

	// Cartridge beats go straight into the memory sender
	assign rom_push      = is_cart && ioctl.wr;
	assign rom_item.addr = ioctl.addr + cfg.rom_base;
	assign rom_item.data = ioctl.data;

	// Offset 14 carries the last half-word, so it bypasses the record register
	assign cheat_push = is_cheat && ioctl.wr && (ioctl.addr[3:0] == 4'd14) && !cfg.cheats_off;
	assign cheat_item = '{flags:   code_q.flags,
	                      address: code_q.address,
	                      compare: code_q.compare,
	                      replace: {ioctl.data, code_q.replace[15:0]}};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q      <= 1'b0;
			bios_wr_q     <= 1'b0;
			cheat_clear_q <= 1'b0;
		end else begin
			active_q      <= ioctl.active;
			cheat_clear_q <= dl_start && is_cheat;         // Engine drops old codes
			bios_wr_q     <= is_bios && ioctl.wr && ioctl.addr[1] && !cfg.homebrew_bios;
		end
	end

	//==========================================================================
	// BIOS words and cheat records
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		if (is_bios && ioctl.wr && !cfg.homebrew_bios) begin
			if (!ioctl.addr[1]) begin
				bios_data_q[15:0] <= ioctl.data;             // Low half waits for its partner
			end else begin
				bios_data_q[31:16] <= ioctl.data;
				bios_addr_q        <= ioctl.addr[BIOS_ADDR_W+1:2];
			end
		end
		if (is_cheat && ioctl.wr) begin
			case (ioctl.addr[3:0])
				4'd0:    code_q.flags[15:0]    <= ioctl.data;
				4'd2:    code_q.flags[31:16]   <= ioctl.data;
				4'd4:    code_q.address[15:0]  <= ioctl.data;
				4'd6:    code_q.address[31:16] <= ioctl.data;
				4'd8:    code_q.compare[15:0]  <= ioctl.data;
				4'd10:   code_q.compare[31:16] <= ioctl.data;
				4'd12:   code_q.replace[15:0]  <= ioctl.data;
				default: ;                                   // Offset 14 completes the record
			endcase
		end
	end

	assign bios        = '{wr: bios_wr_q, addr: bios_addr_q, data: bios_data_q};
	assign cheat_clear = cheat_clear_q;

endmodule

`default_nettype wire

// File: hdl/cart_header_scan.sv
`timescale 1ns/1ps
`default_nettype none

module cart_header_scan (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gba_loader_pkg::ioctl_t     ioctl,
	output gba_loader_pkg::cart_info_t info
);
	import gba_loader_pkg::*;

	`include "quirk_table.svh"

	logic                   cart_now;      // Cartridge download this cycle
	logic                   cart_q;
	logic                   cart_wr;
	logic [7:0]             byte0;         // Earlier byte of the half-word
	logic [7:0]             byte1;
	logic [63:0]            win_q;         // Last eight bytes seen
	logic                   marker_hit;
	logic [ADDR_W-1:0]      title_off;
	logic                   title_byte;
	logic                   title_end;
	logic [8*TITLE_LEN-1:0] title_q;
	quirk_t                 quirk_hit;
	cart_info_t             info_q;

	assign cart_now = ioctl.active && (ioctl.index != IDX_BIOS) && (ioctl.index != IDX_CHEAT);
	assign cart_wr  = cart_now && ioctl.wr;
	assign byte0    = ioctl.data[7:0];
	assign byte1    = ioctl.data[15:8];

	//==========================================================================
	// Flash marker search
	//==========================================================================
	// Marker may end on either byte of the incoming half-word
	assign marker_hit = ({win_q[55:0], byte0, byte1} == FLASH_MARKER) ||
	                    ({win_q, byte0} == FLASH_MARKER);

	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			win_q <= {win_q[47:0], byte0, byte1};
		end
	end

	//==========================================================================
	// Title capture and quirk lookup
	//==========================================================================
	// Addresses below the title wrap to large offsets, so one compare bounds both sides
	assign title_off  = ioctl.addr - ADDR_W'(TITLE_ADDR);
	assign title_byte = title_off < ADDR_W'(TITLE_LEN);
	assign title_end  = ioctl.addr == ADDR_W'(TITLE_ADDR + TITLE_LEN);

	always_ff @(posedge clk_sys) begin
		if (cart_wr && title_byte) begin
			// First title byte lands in the top byte of the register
			title_q[(TITLE_LEN - 2 - int'(title_off[3:0])) * 8 +: 16] <= {byte0, byte1};
		end
	end

	always_comb begin
		quirk_hit = '0;
		for (int i = 0; i < QUIRK_ENTRIES; i++) begin
			if (title_q == QUIRK_TABLE[i].title) begin
				quirk_hit = quirk_hit | QUIRK_TABLE[i].quirks;
			end
		end
	end

	//==========================================================================
	// Cartridge information
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_q <= 1'b0;
			info_q <= '0;
		end else begin
			cart_q <= cart_now;
			if (cart_now && !cart_q) begin             // New cartridge starts
				info_q.loaded    <= 1'b1;
				info_q.cart_type <= ioctl.index[7:6];  // Upper index bits select the cart kind
				info_q.flash_1m  <= 1'b0;
				info_q.quirks    <= '0;
			end
			if (cart_q && !cart_now) begin
				info_q.last_addr <= ioctl.addr;        // Host leaves the final address in place
			end
			if (cart_wr && marker_hit) begin
				info_q.flash_1m <= 1'b1;
			end
			if (cart_wr && title_end) begin
				info_q.quirks <= quirk_hit;            // Title register is complete here
			end
		end
	end

	assign info = info_q;

endmodule

`default_nettype wire

// File: hdl/loader_regs.sv
`timescale 1ns/1ps
`default_nettype none

module loader_regs (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gba_loader_pkg::reg_req_t   reg_req,
	input  logic [1:0]                 reg_addr,
	output logic [31:0]                reg_rdata,
	input  gba_loader_pkg::cart_info_t info,
	output gba_loader_pkg::cfg_t       cfg
);
	import gba_loader_pkg::*;

	cfg_t cfg_q;

	//==========================================================================
	// Register writes
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg_q <= '{homebrew_bios: 1'b0, cheats_off: 1'b0, rom_base: ROM_BASE_RESET};
		end else if (reg_req.wr) begin
			case (reg_req.addr)
				2'd0: begin                                      // Control
					cfg_q.homebrew_bios <= reg_req.data[0];
					cfg_q.cheats_off    <= reg_req.data[1];
				end
				2'd1:    cfg_q.rom_base <= reg_req.data[ADDR_W-1:0];
				default: ;                                       // Status is read only
			endcase
		end
	end

	// Read mux
	always_comb begin
		case (reg_addr)
			2'd0:    reg_rdata = {30'd0, cfg_q.cheats_off, cfg_q.homebrew_bios};
			2'd1:    reg_rdata = 32'(cfg_q.rom_base);
			2'd2:    reg_rdata = 32'({info.quirks, info.flash_1m, info.cart_type, info.loaded});
			default: reg_rdata = 32'(info.last_addr);
		endcase
	end

	assign cfg = cfg_q;

endmodule

`default_nettype wire

// File: hdl/gba_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module gba_loader_top (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  gba_loader_pkg::ioctl_t      ioctl,
	output logic                        ioctl_wait,
	output logic                        rom_valid,
	output gba_loader_pkg::rom_wr_t     rom_wr,
	input  logic                        rom_credit,
	output logic                        cheat_valid,
	output gba_loader_pkg::cheat_code_t cheat_code,
	input  logic                        cheat_credit,
	output logic                        cheat_clear,
	output gba_loader_pkg::bios_wr_t    bios,
	input  gba_loader_pkg::reg_req_t    reg_req,
	output logic [31:0]                 reg_rdata
);
	import gba_loader_pkg::*;

	cfg_t        cfg;
	cart_info_t  info;
	logic        rom_push;
	rom_wr_t     rom_item;
	logic        rom_full;
	logic        cheat_push;
	cheat_code_t cheat_item;
	logic        cheat_full;

	download_decode download_decode_i (
		.clk_sys, .reset, .ioctl, .cfg,
		.rom_push, .rom_item, .rom_full,
		.cheat_push, .cheat_item, .cheat_full,
		.ioctl_wait, .bios, .cheat_clear
	);

	cart_header_scan cart_header_scan_i (.clk_sys, .reset, .ioctl, .info);

	loader_regs loader_regs_i (
		.clk_sys, .reset, .reg_req,
		.reg_addr (reg_req.addr),           // Reads share the request address
		.reg_rdata, .info, .cfg
	);

	// Memory side
	credit_sender #(.PAYLOAD(rom_wr_t), .CREDITS(ROM_CREDITS)) rom_sender_i (
		.clk_sys, .reset,
		.push (rom_push), .item (rom_item), .full (rom_full),
		.valid (rom_valid), .data (rom_wr), .credit (rom_credit)
	);

	// Cheat engine side
	credit_sender #(.PAYLOAD(cheat_code_t), .CREDITS(CHEAT_CREDITS)) cheat_sender_i (
		.clk_sys, .reset,
		.push (cheat_push), .item (cheat_item), .full (cheat_full),
		.valid (cheat_valid), .data (cheat_code), .credit (cheat_credit)
	);

endmodule

`default_nettype wire

// File: tests/gba_loader_chk.sv
`timescale 1ns/1ps
`default_nettype none

module gba_loader_chk #(
	parameter int CREDITS = 1
) (
	input logic clk_sys,
	input logic reset,
	input logic push,
	input logic full,
	input logic valid,
	input logic credit
);
	logic [3:0] outstanding;            // Credits held by the receiver

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			outstanding <= '0;
		end else begin
			outstanding <= outstanding + 4'(valid) - 4'(credit);
		end
	end

	// No second item on the same unreturned credit
	valid_spaced: assert property (@(posedge clk_sys) disable iff (reset)
		(valid && !credit) |=> !valid)
		else $error("valid high twice without a returned credit");

	// A push into a full buffer would drop a beat
	push_fits: assert property (@(posedge clk_sys) disable iff (reset) !(push && full))
		else $error("push while the buffer is full");

	credits_bounded: assert property (@(posedge clk_sys) disable iff (reset)
		outstanding <= 4'(CREDITS))
		else $error("outstanding credits out of range");

	valid_has_credit: assert property (@(posedge clk_sys) disable iff (reset)
		valid |-> (outstanding < 4'(CREDITS)))
		else $error("item presented with no free credit");

endmodule

bind credit_sender gba_loader_chk #(.CREDITS(CREDITS)) credit_chk_i (
	.clk_sys, .reset, .push, .full, .valid, .credit
);

`default_nettype wire

// File: tests/gba_loader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gba_loader_tb;
	import gba_loader_pkg::*;

	localparam int          BEATS_TOTAL     = 352;                // Half-words over all downloads
	localparam int          WATCHDOG_CYCLES = BEATS_TOTAL * 20 + 2000;
	localparam int          HDR_BYTES       = 'hD0;               // Header image length
	localparam logic [31:0] RAND_SEED       = 32'hf1d4513f;

	logic        clk_sys;
	logic        reset;
	ioctl_t      ioctl;
	logic        ioctl_wait;
	logic        rom_valid;
	rom_wr_t     rom_wr;
	logic        rom_credit;
	logic        cheat_valid;
	cheat_code_t cheat_code;
	logic        cheat_credit;
	logic        cheat_clear;
	bios_wr_t    bios;
	reg_req_t    reg_req;
	logic [31:0] reg_rdata;

	int          errors       = 0;
	int          checks       = 0;
	int          cyc          = 0;          // Rising edges so far
	int          rom_owed     = 0;          // Credits the memory model still owes
	int          cheat_owed   = 0;
	int          delay_idx    = 0;
	int          clear_pulses = 0;
	logic        cheat_hold   = 1'b0;       // Cheat sink keeps its credits
	logic        homebrew     = 1'b0;       // Mirror of control bit 0
	logic [26:0] rom_base;                  // Mirror of the ROM base register
	logic [2:0]  delay_tab [256];           // Credit return delays, drawn up front
	logic [7:0]  img [512];                 // Byte image of the next download
	rom_wr_t     rom_exp [$];
	rom_wr_t     rom_got [$];
	bios_wr_t    bios_exp [$];
	bios_wr_t    bios_got [$];
	int          bios_exp_cyc [$];
	int          bios_got_cyc [$];
	cheat_code_t cheat_got [$];

	gba_loader_top gba_loader_top_i (
		.clk_sys, .reset, .ioctl, .ioctl_wait,
		.rom_valid, .rom_wr, .rom_credit,
		.cheat_valid, .cheat_code, .cheat_credit, .cheat_clear,
		.bios, .reg_req, .reg_rdata
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) cyc <= cyc + 1;

	//==========================================================================
	// Memory model, cheat sink and output monitor
	//==========================================================================
	// Outputs settle well before the falling edge
	always @(negedge clk_sys) begin
		if (rom_valid) begin
			rom_got.push_back(rom_wr);
			rom_owed++;
		end
		if (cheat_valid) begin
			cheat_got.push_back(cheat_code);
			cheat_owed++;
		end
		if (bios.wr) begin
			bios_got.push_back(bios);
			bios_got_cyc.push_back(cyc);              // Edge that raised wr
		end
		if (cheat_clear) clear_pulses++;
	end

	initial begin : memory_credits
		forever begin
			wait (rom_owed > 0);
			repeat (delay_tab[delay_idx]) @(posedge clk_sys);
			delay_idx = (delay_idx + 1) % 256;
			@(posedge clk_sys);
			#1;
			rom_credit = 1'b1;                        // One credit per pulse
			rom_owed--;
			@(posedge clk_sys);
			#1;
			rom_credit = 1'b0;
		end
	end

	initial begin : cheat_sink_credits
		forever begin
			wait (cheat_owed > 0 && !cheat_hold);
			@(posedge clk_sys);
			#1;
			cheat_credit = 1'b1;
			cheat_owed--;
			@(posedge clk_sys);
			#1;
			cheat_credit = 1'b0;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	//==========================================================================
	// Helpers
	//==========================================================================
	task automatic expect_equal(input string what, input logic [127:0] got,
	                            input logic [127:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Fail %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;                                           // Drive just after the edge
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
		reg_req = '{wr: 1'b1, addr: addr, data: data};
		next_cycle();
		reg_req.wr = 1'b0;
	endtask

	task automatic compare_reg(input logic [1:0] addr, input logic [31:0] exp,
	                           input string what);
		reg_req = '{wr: 1'b0, addr: addr, data: 32'd0};
		#1;                                           // Read path is combinational
		expect_equal(what, reg_rdata, exp);
	endtask

	// Little endian word from the byte image
	function automatic logic [31:0] le_word(input int a);
		return {img[a+3], img[a+2], img[a+1], img[a]};
	endfunction

	// Flags, address, compare, replace in file order
	function automatic cheat_code_t cheat_record(input int base);
		return '{le_word(base), le_word(base + 4), le_word(base + 8), le_word(base + 12)};
	endfunction

	function automatic logic [31:0] status_word(input logic [1:0] cart_type, input logic flash,
	                                            input quirk_t q);
		return 32'({q, flash, cart_type, 1'b1});      // Loaded in bit 0
	endfunction

	// Streams img as half-words, low byte first, and records what should come out
	task automatic send_image(input logic [7:0] index, input int nbytes);
		logic [15:0] half;
		rom_wr_t     item;
		bios_wr_t    word;
		ioctl.active = 1'b1;
		ioctl.index  = index;
		next_cycle();
		for (int a = 0; a < nbytes; a += 2) begin
			while (ioctl_wait) begin                  // Host holds off
				next_cycle();
			end
			half       = {img[a+1], img[a]};
			ioctl.addr = ADDR_W'(a);
			ioctl.data = half;
			ioctl.wr   = 1'b1;
			next_cycle();
			ioctl.wr   = 1'b0;
			if (index != IDX_BIOS && index != IDX_CHEAT) begin
				item = '{addr: rom_base + ADDR_W'(a), data: half};
				rom_exp.push_back(item);
			end
			if (index == IDX_BIOS && (a % 4) == 2 && !homebrew) begin
				word = '{wr: 1'b1, addr: 12'(a / 4), data: le_word(a - 2)};
				bios_exp.push_back(word);
				bios_exp_cyc.push_back(cyc);          // Edge that took the upper half
			end
		end
		ioctl.active = 1'b0;                          // Final address stays on the bus
		repeat (3) next_cycle();
	endtask

	task automatic drain_rom_items(input int n);
		while (rom_got.size() < rom_exp.size()) next_cycle();
		repeat (8) next_cycle();                      // Room for a stray extra write
		expect_equal("memory write count", rom_got.size(), n);
		for (int i = 0; i < rom_exp.size() && i < rom_got.size(); i++)
			expect_equal($sformatf("memory write %0d", i), rom_got[i], rom_exp[i]);
		rom_got.delete();
		rom_exp.delete();
	endtask

	task automatic drain_bios_writes(input int n);
		expect_equal("BIOS write count", bios_got.size(), n);
		for (int i = 0; i < bios_exp.size() && i < bios_got.size(); i++) begin
			expect_equal($sformatf("BIOS write %0d", i), bios_got[i], bios_exp[i]);
			expect_equal($sformatf("BIOS write %0d cycle", i), bios_got_cyc[i], bios_exp_cyc[i]);
		end
		bios_got.delete();
		bios_exp.delete();
		bios_got_cyc.delete();
		bios_exp_cyc.delete();
	endtask

	task automatic build_header(input logic [95:0] title, input logic marker);
		logic [71:0] flash;
		flash = "FLASH1M_V";
		for (int a = 0; a < HDR_BYTES; a++) img[a] = 8'(a) ^ 8'hA5;
		for (int i = 0; i < TITLE_LEN; i++) img[TITLE_ADDR + i] = title[95 - 8*i -: 8];
		if (marker) begin
			for (int i = 0; i < 9; i++) img['hC1 + i] = flash[71 - 8*i -: 8]; // Odd offset
		end
	endtask

	//==========================================================================
	// Directed tests
	//==========================================================================
	task automatic registers_reset_rw();
		compare_reg(2'd0, 32'd0, "control after reset");
		compare_reg(2'd1, 32'(ROM_BASE_RESET), "ROM base after reset");
		compare_reg(2'd2, 32'd0, "status after reset");
		compare_reg(2'd3, 32'd0, "last address after reset");
		write_reg(2'd0, 32'd3);
		compare_reg(2'd0, 32'd3, "control readback");
		write_reg(2'd0, 32'd0);
		compare_reg(2'd0, 32'd0, "control cleared");
		rom_base = 27'h0234000;
		write_reg(2'd1, 32'(rom_base));
		compare_reg(2'd1, 32'(rom_base), "ROM base readback");
	endtask

	task automatic cart_stream_order();
		for (int a = 0; a < 128; a++) img[a] = 8'($urandom);
		send_image(8'h01, 128);
		drain_rom_items(64);
	endtask

	task automatic header_scan_quirks();
		build_header("POKEMON RUBY", 1'b1);
		send_image(8'h41, HDR_BYTES);                 // Index bits 7:6 are 1
		drain_rom_items(HDR_BYTES / 2);
		compare_reg(2'd2, status_word(2'd1, 1'b1, 5'b00100), "status, first cart");
		compare_reg(2'd3, 32'(HDR_BYTES - 2), "last address, first cart");
		build_header({"BOMBER MAN", 16'h0}, 1'b0);
		send_image(8'h05, HDR_BYTES);
		drain_rom_items(HDR_BYTES / 2);
		compare_reg(2'd2, status_word(2'd0, 1'b0, 5'b11000), "status, second cart");
		compare_reg(2'd3, 32'(HDR_BYTES - 2), "last address, second cart");
	endtask

	task automatic bios_word_writes();
		for (int a = 0; a < 32; a++) img[a] = 8'($urandom);
		send_image(IDX_BIOS, 32);
		drain_bios_writes(8);
		write_reg(2'd0, 32'd1);                       // Built-in BIOS kept
		homebrew = 1'b1;
		send_image(IDX_BIOS, 32);
		drain_bios_writes(0);
		write_reg(2'd0, 32'd0);
		homebrew = 1'b0;
	endtask

	task automatic cheat_record_flow();
		for (int a = 0; a < 64; a++) img[a] = 8'($urandom);
		clear_pulses = 0;
		cheat_hold   = 1'b1;
		fork
			send_image(IDX_CHEAT, 64);
			begin
				wait (ioctl_wait);                    // Two records queued behind the first
				expect_equal("address at pause", ioctl.addr, 27'd46);
				repeat (20) next_cycle();
				expect_equal("address while held", ioctl.addr, 27'd46);
				expect_equal("records while held", cheat_got.size(), 1);
				cheat_hold = 1'b0;
			end
		join
		while (cheat_got.size() < 4) next_cycle();
		repeat (8) next_cycle();                      // A fifth record would show here
		expect_equal("cheat clear pulses", clear_pulses, 1);
		expect_equal("cheat record count", cheat_got.size(), 4);
		for (int r = 0; r < 4; r++)
			expect_equal($sformatf("cheat record %0d", r), cheat_got[r], cheat_record(16 * r));
		cheat_got.delete();
		clear_pulses = 0;
		write_reg(2'd0, 32'd2);                       // Cheats off
		send_image(IDX_CHEAT, 32);
		repeat (10) next_cycle();
		expect_equal("records with cheats off", cheat_got.size(), 0);
		expect_equal("cheat clear, cheats off", clear_pulses, 1);
		write_reg(2'd0, 32'd0);
	endtask

	//==========================================================================
	// Main sequence
	//==========================================================================
	initial begin : main
		int seed_val;
		seed_val     = $urandom(RAND_SEED);
		reset        = 1'b1;
		ioctl        = '0;
		reg_req      = '0;
		rom_credit   = 1'b0;
		cheat_credit = 1'b0;
		rom_base     = ROM_BASE_RESET;
		for (int i = 0; i < 256; i++) delay_tab[i] = 3'($urandom % 6);
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		registers_reset_rw();
		cart_stream_order();
		header_scan_quirks();
		bios_word_writes();
		cheat_record_flow();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hdl/gba_loader_pkg.sv
hdl/credit_sender.sv
hdl/download_decode.sv
hdl/cart_header_scan.sv
hdl/loader_regs.sv
hdl/gba_loader_top.sv
tests/gba_loader_chk.sv
tests/gba_loader_tb.sv

// File: Bender.yml
package:
  name: gba_loader

sources:
  - include_dirs:
      - include
    files:
      - hdl/gba_loader_pkg.sv
      - hdl/credit_sender.sv
      - hdl/download_decode.sv
      - hdl/cart_header_scan.sv
      - hdl/loader_regs.sv
      - hdl/gba_loader_top.sv
  - target: test
    files:
      - tests/gba_loader_chk.sv
      - tests/gba_loader_tb.sv
